/* include/chan_config.svh */
// sizes and timing constants of the channelizer control shell
// bin width limits the FFT size to 2048 points
// reset hold counts must fit the width derived from CHAN_RESET_BOOT

`ifndef CHAN_CONFIG_SVH
`define CHAN_CONFIG_SVH

// complex sample, real in the upper half
`define CHAN_SAMPLE_W 32

// run-time setting widths
`define CHAN_SIZE_W 12
`define CHAN_BIN_W 11
`define CHAN_NFFT_W 5
`define CHAN_PAYLOAD_W 16

// internal reset length in clock cycles
`define CHAN_RESET_HOLD 8
`define CHAN_RESET_BOOT 31

// log2 code for size 8, also the fallback for unsupported sizes
`define CHAN_NFFT_MIN 3

`endif

/* design/chan_pkg.sv */
// shared types of the channelizer shell
// widths come from chan_config.svh, so that header must be on the include path

`include "chan_config.svh"

package chan_pkg;

    // one complex sample as a flat word
    typedef logic [`CHAN_SAMPLE_W-1:0] sample_t;

    // run-time settings
    typedef logic [`CHAN_SIZE_W-1:0] fft_size_t;
    typedef logic [`CHAN_PAYLOAD_W-1:0] payload_len_t;

    // bin index within one FFT frame
    typedef logic [`CHAN_BIN_W-1:0] bin_idx_t;

    // log2 size code for the FFT configuration channel
    typedef logic [`CHAN_NFFT_W-1:0] nfft_t;

    // sample split into halves, re occupies the upper bits
    typedef struct packed {
        logic [`CHAN_SAMPLE_W/2-1:0] re;
        logic [`CHAN_SAMPLE_W/2-1:0] im;
    } iq_sample_t;

    // FFT configuration sequencer
    typedef enum logic {
        CFG_IDLE,
        CFG_SEND
    } cfg_state_t;

endpackage

/* design/chan_reset_ctrl.sv */
// holds the run-time settings and stretches the internal reset
// fft_size_i must be non-zero while sync_reset is high, else the size register stays unknown
// a zero fft_size_i is ignored and keeps the previous size
// a setting change raises core_reset_o on the next clock edge

`timescale 1ns/10ps
`include "chan_config.svh"

module chan_reset_ctrl (
    input  logic                   clk,
    input  logic                   sync_reset,
    input  chan_pkg::fft_size_t    fft_size_i,
    input  chan_pkg::payload_len_t payload_len_i,
    output logic                   core_reset_o,
    output chan_pkg::fft_size_t    fft_size_o,
    output chan_pkg::payload_len_t payload_len_o
);

    localparam int CNT_W = $clog2(`CHAN_RESET_BOOT + 1);

    logic [CNT_W-1:0] hold_cnt;
    logic             setting_chg;

    // zero size is not a change
    assign setting_chg = ((fft_size_i != '0) && (fft_size_i != fft_size_o)) ||
                         (payload_len_i != payload_len_o);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            hold_cnt     <= CNT_W'(`CHAN_RESET_BOOT);
            core_reset_o <= 1'b1;
        end else begin
            if (setting_chg) begin
                hold_cnt <= CNT_W'(`CHAN_RESET_HOLD);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            core_reset_o <= setting_chg || (hold_cnt != '0);
        end
    end

    // settings follow the inputs continuously
    always_ff @(posedge clk) begin
        if (fft_size_i != '0) begin
            fft_size_o <= fft_size_i;
        end
        payload_len_o <= payload_len_i;
    end

    // a new setting in the registers always comes with the internal reset
    a_chg_resets : assert property (@(posedge clk) disable iff (sync_reset)
        ($changed(fft_size_o) || $changed(payload_len_o)) |-> core_reset_o);

endmodule

/* design/fft_cfg_gen.sv */
// FFT configuration generator
// waits for the internal reset to fall, then sends one size code to the FFT core
// valid is registered and rises the cycle after ready is seen high
// sizes other than 8 to 2048 in powers of two fall back to code 3

`timescale 1ns/10ps
`include "chan_config.svh"

module fft_cfg_gen (
    input  logic                clk,
    input  logic                core_reset_i,
    input  chan_pkg::fft_size_t fft_size_i,
    input  logic                fft_cfg_ready_i,
    output logic                fft_cfg_valid_o,
    output chan_pkg::nfft_t     fft_cfg_nfft_o
);

    import chan_pkg::*;

    cfg_state_t state;
    logic       rst_d1;
    logic       rst_d2;
    logic       rst_release;
    nfft_t      nfft_dec;

    assign rst_release = rst_d2 && !rst_d1;

    // log2 of a supported power of two
    always_comb begin
        nfft_dec = nfft_t'(`CHAN_NFFT_MIN);
        for (int i = `CHAN_NFFT_MIN; i <= `CHAN_BIN_W; i++) begin
            if (fft_size_i == fft_size_t'(1 << i)) begin
                nfft_dec = nfft_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge core_reset_i) begin
        if (core_reset_i) begin
            rst_d1          <= 1'b1;
            rst_d2          <= 1'b1;
            state           <= CFG_IDLE;
            fft_cfg_valid_o <= 1'b0;
            fft_cfg_nfft_o  <= nfft_t'(`CHAN_NFFT_MIN);
        end else begin
            rst_d1          <= core_reset_i;
            rst_d2          <= rst_d1;
            fft_cfg_valid_o <= 1'b0;
            case (state)
                CFG_IDLE: begin
                    if (rst_release) begin
                        state <= CFG_SEND;
                    end
                end
                CFG_SEND: begin
                    fft_cfg_nfft_o <= nfft_dec;
                    if (fft_cfg_ready_i) begin
                        fft_cfg_valid_o <= 1'b1;
                        state           <= CFG_IDLE;
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    a_single_pulse : assert property (@(posedge clk) disable iff (core_reset_i)
        fft_cfg_valid_o |=> !fft_cfg_valid_o);

endmodule

/* design/iq_swap_slice.sv */
// single register slice on the sample stream
// exchanges the real and imaginary halves and tags each beat with its bin index
// bins count modulo fft_size_i; sizes above 2048 wrap at the bin width instead
// input ready stays low until one cycle after core reset falls

`timescale 1ns/10ps
`include "chan_config.svh"

module iq_swap_slice (
    input  logic                 clk,
    input  logic                 core_reset_i,
    input  chan_pkg::fft_size_t  fft_size_i,
    input  logic                 s_valid_i,
    input  chan_pkg::sample_t    s_data_i,
    output logic                 s_ready_o,
    output logic                 m_valid_o,
    output chan_pkg::iq_sample_t m_data_o,
    output chan_pkg::bin_idx_t   m_bin_o,
    input  logic                 m_ready_i
);

    import chan_pkg::*;

    localparam int HALF_W = `CHAN_SAMPLE_W / 2;

    logic      run_q;
    logic      full_q;
    logic      accept;
    bin_idx_t  bin_cnt;
    fft_size_t last_bin;
    logic      bin_wrap;

    assign s_ready_o = run_q && (!full_q || m_ready_i);
    assign accept    = s_valid_i && s_ready_o;
    assign m_valid_o = full_q;
    assign last_bin  = fft_size_i - 1'b1;
    assign bin_wrap  = (fft_size_t'(bin_cnt) == last_bin);

    always_ff @(posedge clk or posedge core_reset_i) begin
        if (core_reset_i) begin
            run_q   <= 1'b0;
            full_q  <= 1'b0;
            bin_cnt <= '0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                full_q  <= 1'b1;
                bin_cnt <= bin_wrap ? '0 : bin_cnt + 1'b1;
            end else if (m_ready_i) begin
                full_q <= 1'b0;
            end
        end
    end

    // halves swap on the way in
    always_ff @(posedge clk) begin
        if (accept) begin
            m_data_o.re <= s_data_i[HALF_W-1:0];
            m_data_o.im <= s_data_i[`CHAN_SAMPLE_W-1:HALF_W];
            m_bin_o     <= bin_cnt;
        end
    end

    a_stall_stable : assert property (@(posedge clk) disable iff (core_reset_i)
        (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o) && $stable(m_bin_o)));

endmodule

/* design/payload_framer.sv */
// marks the last sample of each payload on the output stream
// no added latency, ready passes straight back to the slice
// payload_len_i must be non-zero once core reset has fallen

`timescale 1ns/10ps

module payload_framer (
    input  logic                   clk,
    input  logic                   core_reset_i,
    input  chan_pkg::payload_len_t payload_len_i,
    input  logic                   s_valid_i,
    input  chan_pkg::iq_sample_t   s_data_i,
    input  chan_pkg::bin_idx_t     s_bin_i,
    output logic                   s_ready_o,
    output logic                   m_valid_o,
    output chan_pkg::sample_t      m_data_o,
    output chan_pkg::bin_idx_t     m_bin_o,
    output logic                   m_last_o,
    input  logic                   m_ready_i
);

    import chan_pkg::*;

    payload_len_t len_m1_q;
    payload_len_t beat_cnt;
    logic         at_last;
    logic         xfer;

    assign s_ready_o = m_ready_i;
    assign m_valid_o = s_valid_i;
    assign m_data_o  = s_data_i;
    assign m_bin_o   = s_bin_i;
    assign xfer      = s_valid_i && m_ready_i;
    assign at_last   = (beat_cnt == len_m1_q);
    assign m_last_o  = s_valid_i && at_last;

    // terminal count, settles well inside the reset hold
    always_ff @(posedge clk) begin
        len_m1_q <= payload_len_i - 1'b1;
    end

    always_ff @(posedge clk or posedge core_reset_i) begin
        if (core_reset_i) begin
            beat_cnt <= '0;
        end else if (xfer) begin
            beat_cnt <= at_last ? '0 : beat_cnt + 1'b1;
        end
    end

    a_len_nonzero : assert property (@(posedge clk) disable iff (core_reset_i)
        payload_len_i != '0);

endmodule

/* design/chan_top.sv */
// control and framing shell of the M/2 polyphase channelizer
// the FFT core sits outside; its configuration channel appears as ports only
// stream input and output follow AXI-stream valid/ready rules
// sample format is real in the upper half, imaginary in the lower half
// any change of fft_size_i or payload_len_i re-arms the whole pipeline

`timescale 1ns/10ps

module chan_top (
    input  logic                   clk,
    input  logic                   sync_reset,

    input  logic                   s_valid_i,
    input  chan_pkg::sample_t      s_data_i,
    output logic                   s_ready_o,

    input  chan_pkg::fft_size_t    fft_size_i,
    input  chan_pkg::payload_len_t payload_len_i,

    input  logic                   fft_cfg_ready_i,
    output logic                   fft_cfg_valid_o,
    output chan_pkg::nfft_t        fft_cfg_nfft_o,

    output logic                   core_reset_o,

    output logic                   m_valid_o,
    output chan_pkg::sample_t      m_data_o,
    output chan_pkg::bin_idx_t     m_bin_o,
    output logic                   m_last_o,
    input  logic                   m_ready_i
);

    import chan_pkg::*;

    logic         core_reset;
    fft_size_t    fft_size_q;
    payload_len_t payload_len_q;

    // slice to framer
    logic         slice_valid;
    iq_sample_t   slice_data;
    bin_idx_t     slice_bin;
    logic         slice_ready;

    assign core_reset_o = core_reset;

    chan_reset_ctrl u_reset_ctrl (
        .clk           (clk),
        .sync_reset    (sync_reset),
        .fft_size_i    (fft_size_i),
        .payload_len_i (payload_len_i),
        .core_reset_o  (core_reset),
        .fft_size_o    (fft_size_q),
        .payload_len_o (payload_len_q)
    );

    fft_cfg_gen u_cfg_gen (
        .clk             (clk),
        .core_reset_i    (core_reset),
        .fft_size_i      (fft_size_q),
        .fft_cfg_ready_i (fft_cfg_ready_i),
        .fft_cfg_valid_o (fft_cfg_valid_o),
        .fft_cfg_nfft_o  (fft_cfg_nfft_o)
    );

    iq_swap_slice u_slice (
        .clk          (clk),
        .core_reset_i (core_reset),
        .fft_size_i   (fft_size_q),
        .s_valid_i    (s_valid_i),
        .s_data_i     (s_data_i),
        .s_ready_o    (s_ready_o),
        .m_valid_o    (slice_valid),
        .m_data_o     (slice_data),
        .m_bin_o      (slice_bin),
        .m_ready_i    (slice_ready)
    );

    payload_framer u_framer (
        .clk           (clk),
        .core_reset_i  (core_reset),
        .payload_len_i (payload_len_q),
        .s_valid_i     (slice_valid),
        .s_data_i      (slice_data),
        .s_bin_i       (slice_bin),
        .s_ready_o     (slice_ready),
        .m_valid_o     (m_valid_o),
        .m_data_o      (m_data_o),
        .m_bin_o       (m_bin_o),
        .m_last_o      (m_last_o),
        .m_ready_i     (m_ready_i)
    );

endmodule

/* tb/tb_clk_gen.sv */
// clock and power-on reset for the channelizer testbench
// 20 ns period, reset high for two rising edges, released on a falling edge

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic sync_reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        sync_reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        sync_reset_o = 1'b0;
    end

endmodule

/* tb/tb_chan_top.sv */
// random stimulus against a queue model of the channelizer shell
// five settings phases, then the output stream is drained
// fixed LCG seed, so every run sees the same stimulus
// inputs change on the falling edge, results are sampled 1 ns later

`timescale 1ns/10ps

module tb_chan_top;

    import chan_pkg::*;

    localparam int P1_CYCLES   = 400;
    localparam int P2_CYCLES   = 400;
    localparam int P3_CYCLES   = 300;
    localparam int P4_CYCLES   = 300;
    localparam int P5_CYCLES   = 200;
    localparam int DRAIN_MAX   = 64;
    localparam int CYCLE_LIMIT = (P1_CYCLES + P2_CYCLES + P3_CYCLES + P4_CYCLES +
                                  P5_CYCLES + DRAIN_MAX) * 3 / 2;
    localparam int HALF_W      = $bits(sample_t) / 2;

    // one expected output beat
    typedef struct packed {
        sample_t  data;
        bin_idx_t bin;
        logic     last;
    } exp_beat_t;

    logic         clk;
    logic         sync_reset;
    logic         s_valid_i;
    sample_t      s_data_i;
    logic         s_ready_o;
    fft_size_t    fft_size_i;
    payload_len_t payload_len_i;
    logic         fft_cfg_ready_i;
    logic         fft_cfg_valid_o;
    nfft_t        fft_cfg_nfft_o;
    logic         core_reset_o;
    logic         m_valid_o;
    sample_t      m_data_o;
    bin_idx_t     m_bin_o;
    logic         m_last_o;
    logic         m_ready_i;

    exp_beat_t    exp_q[$];
    logic [31:0]  rng;
    int           model_size;
    int           model_len;
    int           bin_cnt;
    int           frame_cnt;
    logic         beat_pending;
    logic         rst_prev;
    logic         chg_armed;
    logic         chg_due;
    logic         cfg_open;
    int           cfg_pulses;
    int           err_data;
    int           err_bin;
    int           err_last;
    int           err_ctrl;
    int           cycle_cnt;
    int           drain_cnt;

    tb_clk_gen u_clk_gen (
        .clk_o        (clk),
        .sync_reset_o (sync_reset)
    );

    chan_top dut (
        .clk             (clk),
        .sync_reset      (sync_reset),
        .s_valid_i       (s_valid_i),
        .s_data_i        (s_data_i),
        .s_ready_o       (s_ready_o),
        .fft_size_i      (fft_size_i),
        .payload_len_i   (payload_len_i),
        .fft_cfg_ready_i (fft_cfg_ready_i),
        .fft_cfg_valid_o (fft_cfg_valid_o),
        .fft_cfg_nfft_o  (fft_cfg_nfft_o),
        .core_reset_o    (core_reset_o),
        .m_valid_o       (m_valid_o),
        .m_data_o        (m_data_o),
        .m_bin_o         (m_bin_o),
        .m_last_o        (m_last_o),
        .m_ready_i       (m_ready_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // log2 code expected by the FFT core
    function automatic int nfft_for_size(input int size);
        case (size)
            8:       return 3;
            16:      return 4;
            32:      return 5;
            64:      return 6;
            128:     return 7;
            256:     return 8;
            512:     return 9;
            1024:    return 10;
            2048:    return 11;
            default: return 3;
        endcase
    endfunction

    function automatic int total_errors();
        return err_data + err_bin + err_last + err_ctrl;
    endfunction

    task automatic print_summary();
        $display("error counts: data %0d, bin %0d, last %0d, control %0d, total %0d",
                 err_data, err_bin, err_last, err_ctrl, total_errors());
    endtask

    task automatic close_cfg_window();
        if (cfg_open && cfg_pulses != 1) begin
            err_ctrl++;
            $display("expected one FFT configuration pulse after reset, saw %0d", cfg_pulses);
        end
        cfg_open = 1'b0;
    endtask

    // zero size is ignored by the DUT and by the model
    task automatic apply_settings(input int size, input int len);
        if ((size != 0 && size != model_size) || len != model_len) begin
            chg_armed = 1'b1;
        end
        fft_size_i    = fft_size_t'(size);
        payload_len_i = payload_len_t'(len);
        if (size != 0) begin
            model_size = size;
        end
        model_len = len;
    endtask

    task automatic drive_stream(input logic allow_new);
        rng             = lcg_next(rng);
        m_ready_i       = (rng[30:24] < 7'd90);
        fft_cfg_ready_i = rng[17];
        // a waiting beat keeps valid and data
        if (!beat_pending) begin
            rng       = lcg_next(rng);
            s_valid_i = allow_new && rng[29];
            rng       = lcg_next(rng);
            s_data_i  = rng;
        end
    endtask

    task automatic check_cycle();
        exp_beat_t exp_beat;
        logic      accept;
        logic      xfer;
        logic      exp_ready;
        accept = s_valid_i && s_ready_o;
        xfer   = m_valid_o && m_ready_i;
        if (chg_due && !core_reset_o) begin
            err_ctrl++;
            $display("core reset did not rise on the cycle after a setting change");
        end
        if (core_reset_o && !rst_prev && !chg_due) begin
            err_ctrl++;
            $display("core reset rose without a setting change");
        end
        chg_due   = chg_armed;
        chg_armed = 1'b0;
        if (core_reset_o && !rst_prev) begin
            close_cfg_window();
        end
        if (!core_reset_o && rst_prev) begin
            cfg_open   = 1'b1;
            cfg_pulses = 0;
        end
        if (fft_cfg_valid_o) begin
            if (!cfg_open) begin
                err_ctrl++;
                $display("FFT configuration pulse outside a reset release window");
            end else begin
                cfg_pulses++;
                if (fft_cfg_nfft_o != nfft_t'(nfft_for_size(model_size))) begin
                    err_ctrl++;
                    $display("ERR fft_cfg_nfft_o: got %h expected %h", fft_cfg_nfft_o,
                             nfft_t'(nfft_for_size(model_size)));
                end
            end
        end
        if (core_reset_o) begin
            if (s_ready_o != 1'b0) begin
                err_ctrl++;
                $display("ERR s_ready_o: got %h expected %h", s_ready_o, 1'b0);
            end
            if (m_valid_o != 1'b0) begin
                err_ctrl++;
                $display("ERR m_valid_o: got %h expected %h", m_valid_o, 1'b0);
            end
            // beats in flight are dropped by the reset
            exp_q.delete();
            bin_cnt   = 0;
            frame_cnt = 0;
        end else begin
            // input opens once the slice is empty or its beat leaves
            if (!rst_prev) begin
                exp_ready = (exp_q.size() == 0) || m_ready_i;
                if (s_ready_o != exp_ready) begin
                    err_ctrl++;
                    $display("ERR s_ready_o: got %h expected %h", s_ready_o, exp_ready);
                end
            end
            if (xfer) begin
                if (exp_q.size() == 0) begin
                    err_data++;
                    $display("output transfer with no sample expected");
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (m_data_o != exp_beat.data) begin
                        err_data++;
                        $display("ERR m_data_o: got %h expected %h", m_data_o, exp_beat.data);
                    end
                    if (m_bin_o != exp_beat.bin) begin
                        err_bin++;
                        $display("ERR m_bin_o: got %h expected %h", m_bin_o, exp_beat.bin);
                    end
                    if (m_last_o != exp_beat.last) begin
                        err_last++;
                        $display("ERR m_last_o: got %h expected %h", m_last_o, exp_beat.last);
                    end
                end
            end
            if (accept) begin
                exp_beat.data = {s_data_i[HALF_W-1:0], s_data_i[2*HALF_W-1:HALF_W]};
                exp_beat.bin  = bin_idx_t'(bin_cnt);
                exp_beat.last = (frame_cnt == model_len - 1);
                exp_q.push_back(exp_beat);
                bin_cnt   = (bin_cnt == model_size - 1) ? 0 : bin_cnt + 1;
                frame_cnt = exp_beat.last ? 0 : frame_cnt + 1;
            end
        end
        beat_pending = s_valid_i && !accept;
        rst_prev     = core_reset_o;
    endtask

    task automatic do_cycle(input logic allow_new);
        @(negedge clk);
        drive_stream(allow_new);
        #1;
        check_cycle();
    endtask

    task automatic run_phase(input int size, input int len, input int n_cycles);
        @(negedge clk);
        apply_settings(size, len);
        drive_stream(1'b1);
        #1;
        check_cycle();
        repeat (n_cycles - 1) do_cycle(1'b1);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            print_summary();
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rng             = 32'd48;
        s_valid_i       = 1'b0;
        s_data_i        = '0;
        fft_size_i      = fft_size_t'(8);
        payload_len_i   = payload_len_t'(5);
        fft_cfg_ready_i = 1'b0;
        m_ready_i       = 1'b0;
        model_size      = 8;
        model_len       = 5;
        bin_cnt         = 0;
        frame_cnt       = 0;
        beat_pending    = 1'b0;
        rst_prev        = 1'b1;
        chg_armed       = 1'b0;
        chg_due         = 1'b0;
        cfg_open        = 1'b0;
        cfg_pulses      = 0;
        err_data        = 0;
        err_bin         = 0;
        err_last        = 0;
        err_ctrl        = 0;
        cycle_cnt       = 0;
        drain_cnt       = 0;
        wait (!sync_reset);

        run_phase(8, 5, P1_CYCLES);
        run_phase(32, 16, P2_CYCLES);
        // payload length alone
        run_phase(32, 5, P3_CYCLES);
        // unsupported size, code falls back to 3
        run_phase(100, 16, P4_CYCLES);
        // zero size must leave everything running
        run_phase(0, 16, P5_CYCLES);

        while ((exp_q.size() != 0 || s_valid_i) && drain_cnt < DRAIN_MAX) begin
            do_cycle(1'b0);
            drain_cnt++;
        end
        if (exp_q.size() != 0) begin
            err_data++;
            $display("%0d accepted samples never left the DUT", exp_q.size());
        end
        close_cfg_window();

        print_summary();
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
design/chan_pkg.sv
design/chan_reset_ctrl.sv
design/fft_cfg_gen.sv
design/iq_swap_slice.sv
design/payload_framer.sv
design/chan_top.sv
tb/tb_clk_gen.sv
tb/tb_chan_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the channelizer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_chan_top -o sim_chan

sim_out="$(./obj_dir/sim_chan)"
printf '%s\n' "$sim_out"

grep -qx "Done: no errors" <<< "$sim_out"
